//--- verilog/ulpi_pkg.sv
package ulpi_pkg;

  // APB word addresses
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_PHY    = 8'h04;
  localparam logic [7:0] REG_HSK    = 8'h08;
  localparam logic [7:0] REG_STATUS = 8'h0c;

  // TX CMD codes in the top two bits
  localparam logic [1:0] TXCMD_TRANSMIT = 2'b01;
  localparam logic [1:0] TXCMD_REGWRITE = 2'b10;

  // Bus value while stp is high
  localparam logic [7:0] TX_STOP_DATA = 8'h00;

  // Transmit view, PID in the low nibble
  typedef struct packed {
    logic [1:0] code;
    logic [1:0] zero;
    logic [3:0] pid;
  } txcmd_xmit_s;

  // Register write view, six-bit PHY address
  typedef struct packed {
    logic [1:0] code;
    logic [5:0] addr;
  } txcmd_regw_s;

  // One TX CMD byte, two decodings
  typedef union packed {
    txcmd_xmit_s xmit;
    txcmd_regw_s regw;
  } ulpi_txcmd_u;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_s;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_s;

  // Packet stream, PID rides on tuser
  typedef struct packed {
    logic       tvalid;
    logic       tlast;
    logic [3:0] tuser;
    logic [7:0] tdata;
  } usb_stream_s;

  typedef struct packed {
    logic       write;
    logic [5:0] addr;
    logic [7:0] data;
  } phy_cmd_s;

  typedef struct packed {
    logic       send;
    logic [3:0] pid;
  } hsk_cmd_s;

  // Done bits are single-cycle pulses
  typedef struct packed {
    logic busy;
    logic reg_done;
    logic hsk_done;
    logic usb_done;
  } enc_status_s;

  // Encoder FSM, one-hot
  typedef enum logic [8:0] {
    IDLE = 9'h001,
    XPID = 9'h002,
    DATA = 9'h004,
    CRC0 = 9'h008,
    CRC1 = 9'h010,
    LAST = 9'h020,
    REGW = 9'h040,
    STOP = 9'h080,
    DONE = 9'h100
  } enc_state_e;

endpackage

//--- verilog/ulpi_tx_regs.sv
`timescale 1ns/1ps
module ulpi_tx_regs (
  input  logic                  clock,
  input  logic                  reset,
  input  ulpi_pkg::apb_req_s    apb_req_i,
  output ulpi_pkg::apb_rsp_s    apb_rsp_o,
  input  ulpi_pkg::enc_status_s enc_status_i,
  output ulpi_pkg::phy_cmd_s    phy_cmd_o,
  output ulpi_pkg::hsk_cmd_s    hsk_cmd_o
);

  logic       access;
  logic       mapped;
  logic       wr_en;
  logic [5:0] phy_addr_q;
  logic [7:0] phy_data_q;
  logic [3:0] hsk_pid_q;
  logic       phy_pend_q;
  logic       hsk_pend_q;
  logic       reg_done_q;
  logic       hsk_done_q;

  // Access phase, pready is tied high
  assign access = apb_req_i.psel && apb_req_i.penable;
  assign mapped = apb_req_i.paddr inside {ulpi_pkg::REG_CTRL, ulpi_pkg::REG_PHY,
                                          ulpi_pkg::REG_HSK, ulpi_pkg::REG_STATUS};
  // Unmapped writes are dropped
  assign wr_en  = access && apb_req_i.pwrite && mapped;

  // PHY address/data and handshake PID
  always_ff @(posedge clock) begin
    if (wr_en && apb_req_i.paddr == ulpi_pkg::REG_PHY) begin
      phy_addr_q <= apb_req_i.pwdata[5:0];
      phy_data_q <= apb_req_i.pwdata[15:8];
    end
    if (wr_en && apb_req_i.paddr == ulpi_pkg::REG_HSK) begin
      hsk_pid_q <= apb_req_i.pwdata[3:0];
    end
  end

  // Pending requests and sticky done flags
  always_ff @(posedge clock) begin
    if (reset) begin
      phy_pend_q <= 1'b0;
      hsk_pend_q <= 1'b0;
      reg_done_q <= 1'b0;
      hsk_done_q <= 1'b0;
    end else begin
      // Request held until the encoder pulses done
      if (enc_status_i.reg_done) begin
        phy_pend_q <= 1'b0;
      end else if (wr_en && apb_req_i.paddr == ulpi_pkg::REG_CTRL &&
                   apb_req_i.pwdata[0] && !phy_pend_q) begin
        phy_pend_q <= 1'b1;
      end
      if (enc_status_i.hsk_done) begin
        hsk_pend_q <= 1'b0;
      end else if (wr_en && apb_req_i.paddr == ulpi_pkg::REG_CTRL &&
                   apb_req_i.pwdata[1] && !hsk_pend_q) begin
        hsk_pend_q <= 1'b1;
      end
      // Write one to clear, a new done wins
      if (enc_status_i.reg_done) begin
        reg_done_q <= 1'b1;
      end else if (wr_en && apb_req_i.paddr == ulpi_pkg::REG_STATUS && apb_req_i.pwdata[1]) begin
        reg_done_q <= 1'b0;
      end
      if (enc_status_i.hsk_done) begin
        hsk_done_q <= 1'b1;
      end else if (wr_en && apb_req_i.paddr == ulpi_pkg::REG_STATUS && apb_req_i.pwdata[2]) begin
        hsk_done_q <= 1'b0;
      end
    end
  end

  // Read mux straight from paddr
  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = access && !mapped;
    case (apb_req_i.paddr)
      ulpi_pkg::REG_PHY:    apb_rsp_o.prdata = {16'h0000, phy_data_q, 2'b00, phy_addr_q};
      ulpi_pkg::REG_HSK:    apb_rsp_o.prdata = {28'h0000000, hsk_pid_q};
      ulpi_pkg::REG_STATUS: begin
        // Busy covers queued jobs too
        apb_rsp_o.prdata[0] = enc_status_i.busy || phy_pend_q || hsk_pend_q;
        apb_rsp_o.prdata[1] = reg_done_q;
        apb_rsp_o.prdata[2] = hsk_done_q;
      end
      default: apb_rsp_o.prdata = '0;
    endcase
  end

  assign phy_cmd_o = '{write: phy_pend_q, addr: phy_addr_q, data: phy_data_q};
  assign hsk_cmd_o = '{send: hsk_pend_q, pid: hsk_pid_q};

endmodule

//--- verilog/usb_crc16.sv
`timescale 1ns/1ps
module usb_crc16 (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear_i,
  input  logic        byte_valid_i,
  input  logic [7:0]  byte_i,
  output logic [15:0] crc_o
);

  logic [15:0] crc_q;
  logic [15:0] crc_next;
  logic        fb;

  // Poly 0x8005, bytes enter LSB first
  always_comb begin
    crc_next = crc_q;
    fb       = 1'b0;
    for (int i = 0; i < 8; i++) begin
      fb       = crc_next[15] ^ byte_i[i];
      crc_next = {crc_next[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
    end
  end

  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      crc_q <= 16'hffff;
    end else if (byte_valid_i) begin
      crc_q <= crc_next;
    end
  end

  // Complemented and reversed, low byte goes out first
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc_o[i] = ~crc_q[15-i];
    end
  end

endmodule

//--- verilog/skid_loader.sv
`timescale 1ns/1ps
module skid_loader (
  input  logic       clock,
  input  logic       reset,
  input  logic       s_valid_i,
  output logic       s_ready_o,
  input  logic       s_last_i,
  input  logic [7:0] s_data_i,
  input  logic       t_valid_i,
  input  logic       t_last_i,
  input  logic [7:0] t_data_i,
  output logic       t_ready_o,
  output logic       m_valid_o,
  input  logic       m_ready_i,
  output logic       m_last_o,
  output logic [7:0] m_data_o
);

  logic       m_valid_q;
  logic       m_last_q;
  logic [7:0] m_data_q;
  logic       tmp_valid_q;
  logic       tmp_last_q;
  logic [7:0] tmp_data_q;
  logic       ending;
  logic       out_free;
  logic       s_fire;
  logic       t_fire;

  // Last entry is shown for one cycle regardless of m_ready
  assign ending    = m_valid_q && m_last_q;
  assign out_free  = !m_valid_q || m_ready_i;
  // No new entries while the temp slot is full or a job is closing
  assign s_ready_o = !tmp_valid_q && !ending;
  assign t_ready_o = !tmp_valid_q && !ending;
  assign s_fire    = s_valid_i && s_ready_o;
  assign t_fire    = t_valid_i && t_ready_o;

  always_ff @(posedge clock) begin
    if (reset || ending) begin
      m_valid_q   <= 1'b0;
      m_last_q    <= 1'b0;
      m_data_q    <= 8'h00;
      tmp_valid_q <= 1'b0;
    end else if (out_free) begin
      if (tmp_valid_q) begin
        // Drain the temp slot first to keep order
        m_valid_q   <= 1'b1;
        m_last_q    <= tmp_last_q;
        m_data_q    <= tmp_data_q;
        tmp_valid_q <= 1'b0;
      end else begin
        // Idle bus reads as zero
        m_valid_q   <= s_fire;
        m_last_q    <= s_fire && s_last_i;
        m_data_q    <= s_fire ? s_data_i : 8'h00;
        tmp_valid_q <= t_fire;
      end
    end else begin
      // Temp slot keeps its entry or catches the incoming byte while the output stalls
      tmp_valid_q <= tmp_valid_q || t_fire || s_fire;
    end
  end

  // Direct load wins over the source for the temp payload
  always_ff @(posedge clock) begin
    if (t_fire) begin
      tmp_last_q <= t_last_i;
      tmp_data_q <= t_data_i;
    end else if (s_fire && !out_free) begin
      tmp_last_q <= s_last_i;
      tmp_data_q <= s_data_i;
    end
  end

  assign m_valid_o = m_valid_q;
  assign m_last_o  = m_last_q;
  assign m_data_o  = m_data_q;

endmodule

//--- verilog/ulpi_encoder.sv
`timescale 1ns/1ps
module ulpi_encoder (
  input  logic                  clock,
  input  logic                  reset,
  input  ulpi_pkg::usb_stream_s stream_i,
  output logic                  stream_ready_o,
  input  ulpi_pkg::phy_cmd_s    phy_cmd_i,
  input  ulpi_pkg::hsk_cmd_s    hsk_cmd_i,
  output ulpi_pkg::enc_status_s status_o,
  input  logic                  ulpi_dir_i,
  input  logic                  ulpi_nxt_i,
  output logic                  ulpi_stp_o,
  output logic [7:0]            ulpi_data_o
);

  ulpi_pkg::enc_state_e  state_q;
  ulpi_pkg::ulpi_txcmd_u txcmd;
  logic        dir_q;
  logic        hold;
  logic        reg_job_q;
  logic        hsk_job_q;
  logic        start_reg;
  logic        start_hsk;
  logic        start_usb;
  logic        beat_fire;
  logic        s_valid;
  logic        s_last;
  logic [7:0]  s_data;
  logic        t_valid;
  logic        t_last;
  logic [7:0]  t_data;
  logic        s_ready_w;
  logic        t_ready_w;
  logic        m_valid_w;
  logic        m_ready_w;
  logic        m_last_w;
  logic [7:0]  m_data_w;
  logic [15:0] crc_w;

  // PHY owns the bus now or is turning it around
  assign hold      = ulpi_dir_i || dir_q;
  assign m_ready_w = ulpi_nxt_i && !ulpi_dir_i;
  assign beat_fire = stream_i.tvalid && stream_ready_o;

  // Job pick in IDLE, register write first, then handshake, then stream
  always_comb begin
    start_reg = 1'b0;
    start_hsk = 1'b0;
    start_usb = 1'b0;
    if (state_q == ulpi_pkg::IDLE && !hold && s_ready_w && t_ready_w) begin
      start_reg = phy_cmd_i.write;
      start_hsk = !phy_cmd_i.write && hsk_cmd_i.send;
      start_usb = !phy_cmd_i.write && !hsk_cmd_i.send && stream_i.tvalid;
    end
  end

  // TX CMD byte, same priority as the job pick
  always_comb begin
    txcmd = '0;
    if (phy_cmd_i.write) begin
      txcmd.regw.code = ulpi_pkg::TXCMD_REGWRITE;
      txcmd.regw.addr = phy_cmd_i.addr;
    end else begin
      txcmd.xmit.code = ulpi_pkg::TXCMD_TRANSMIT;
      txcmd.xmit.zero = 2'b00;
      // PID comes from the waiting first beat
      txcmd.xmit.pid  = hsk_cmd_i.send ? hsk_cmd_i.pid : stream_i.tuser;
    end
  end

  // Data-out mux into the skid loader
  always_comb begin
    s_valid        = 1'b0;
    s_last         = 1'b0;
    s_data         = ulpi_pkg::TX_STOP_DATA;
    t_valid        = 1'b0;
    t_last         = 1'b0;
    t_data         = ulpi_pkg::TX_STOP_DATA;
    stream_ready_o = 1'b0;
    if (!hold) begin
      case (state_q)
        ulpi_pkg::IDLE: begin
          s_valid = start_reg || start_hsk || start_usb;
          s_data  = txcmd;
          // Temp slot gets the register data or the handshake stop marker
          t_valid = start_reg || start_hsk;
          t_last  = start_hsk;
          t_data  = start_reg ? phy_cmd_i.data : ulpi_pkg::TX_STOP_DATA;
        end
        ulpi_pkg::XPID, ulpi_pkg::DATA: begin
          // Payload may queue behind the TX CMD
          if (!hsk_job_q) begin
            stream_ready_o = s_ready_w;
            s_valid        = stream_i.tvalid;
            s_data         = stream_i.tdata;
          end
        end
        ulpi_pkg::CRC0: begin
          s_valid = 1'b1;
          s_data  = crc_w[7:0];
        end
        ulpi_pkg::CRC1: begin
          s_valid = 1'b1;
          s_data  = crc_w[15:8];
        end
        ulpi_pkg::LAST, ulpi_pkg::REGW: begin
          s_valid = 1'b1;
          s_last  = 1'b1;
        end
        default: s_valid = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= ulpi_pkg::IDLE;
      dir_q     <= 1'b0;
      reg_job_q <= 1'b0;
      hsk_job_q <= 1'b0;
    end else begin
      dir_q <= ulpi_dir_i;
      if (!hold) begin
        case (state_q)
          ulpi_pkg::IDLE: begin
            if (start_reg) begin
              state_q   <= ulpi_pkg::REGW;
              reg_job_q <= 1'b1;
              hsk_job_q <= 1'b0;
            end else if (start_hsk || start_usb) begin
              state_q   <= ulpi_pkg::XPID;
              reg_job_q <= 1'b0;
              hsk_job_q <= start_hsk;
            end
          end
          ulpi_pkg::XPID: begin
            // First pop of the job is always the TX CMD
            if (beat_fire && stream_i.tlast) begin
              state_q <= ulpi_pkg::CRC0;
            end else if (m_valid_w && m_ready_w) begin
              state_q <= hsk_job_q ? ulpi_pkg::STOP : ulpi_pkg::DATA;
            end
          end
          ulpi_pkg::DATA: if (beat_fire && stream_i.tlast) state_q <= ulpi_pkg::CRC0;
          ulpi_pkg::CRC0: if (s_ready_w) state_q <= ulpi_pkg::CRC1;
          ulpi_pkg::CRC1: if (s_ready_w) state_q <= ulpi_pkg::LAST;
          ulpi_pkg::LAST, ulpi_pkg::REGW: if (s_ready_w) state_q <= ulpi_pkg::STOP;
          // Stop marker gone once the skid is empty again
          ulpi_pkg::STOP: if (!m_valid_w && s_ready_w) state_q <= ulpi_pkg::DONE;
          default: state_q <= ulpi_pkg::IDLE;
        endcase
      end
    end
  end

  assign status_o.busy     = state_q != ulpi_pkg::IDLE;
  assign status_o.reg_done = state_q == ulpi_pkg::DONE && !hold && reg_job_q;
  assign status_o.hsk_done = state_q == ulpi_pkg::DONE && !hold && hsk_job_q;
  assign status_o.usb_done = state_q == ulpi_pkg::DONE && !hold && !reg_job_q && !hsk_job_q;

  // CRC over payload beats taken from the stream
  usb_crc16 u_crc (
    .clock       (clock),
    .reset       (reset),
    .clear_i     (state_q == ulpi_pkg::DONE),
    .byte_valid_i(beat_fire),
    .byte_i      (stream_i.tdata),
    .crc_o       (crc_w)
  );

  // nxt drains the output, the last entry is the stp cycle
  skid_loader u_skid (
    .clock    (clock),
    .reset    (reset),
    .s_valid_i(s_valid),
    .s_ready_o(s_ready_w),
    .s_last_i (s_last),
    .s_data_i (s_data),
    .t_valid_i(t_valid),
    .t_last_i (t_last),
    .t_data_i (t_data),
    .t_ready_o(t_ready_w),
    .m_valid_o(m_valid_w),
    .m_ready_i(m_ready_w),
    .m_last_o (m_last_w),
    .m_data_o (m_data_w)
  );

  assign ulpi_stp_o  = m_last_w;
  assign ulpi_data_o = m_data_w;

endmodule

//--- verilog/ulpi_tx_top.sv
`timescale 1ns/1ps
module ulpi_tx_top (
  input  logic                  clock,
  input  logic                  reset,
  input  ulpi_pkg::apb_req_s    apb_req_i,
  output ulpi_pkg::apb_rsp_s    apb_rsp_o,
  input  ulpi_pkg::usb_stream_s stream_i,
  output logic                  stream_ready_o,
  input  logic                  ulpi_dir_i,
  input  logic                  ulpi_nxt_i,
  output logic                  ulpi_stp_o,
  output logic [7:0]            ulpi_data_o
);

  // Register block to encoder
  ulpi_pkg::phy_cmd_s    phy_cmd_w;
  ulpi_pkg::hsk_cmd_s    hsk_cmd_w;
  // Encoder back to register block
  ulpi_pkg::enc_status_s status_w;

  ulpi_tx_regs u_regs (
    .clock       (clock),
    .reset       (reset),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .enc_status_i(status_w),
    .phy_cmd_o   (phy_cmd_w),
    .hsk_cmd_o   (hsk_cmd_w)
  );

  // Data pins are output only here, pad tristate sits above
  ulpi_encoder u_enc (
    .clock         (clock),
    .reset         (reset),
    .stream_i      (stream_i),
    .stream_ready_o(stream_ready_o),
    .phy_cmd_i     (phy_cmd_w),
    .hsk_cmd_i     (hsk_cmd_w),
    .status_o      (status_w),
    .ulpi_dir_i    (ulpi_dir_i),
    .ulpi_nxt_i    (ulpi_nxt_i),
    .ulpi_stp_o    (ulpi_stp_o),
    .ulpi_data_o   (ulpi_data_o)
  );

endmodule

//--- sim/tb_ulpi_tx.sv
`timescale 1ns/1ps
module tb_ulpi_tx;

  logic                  clock;
  logic                  reset;
  ulpi_pkg::apb_req_s    apb_req_i;
  ulpi_pkg::apb_rsp_s    apb_rsp_o;
  ulpi_pkg::usb_stream_s stream_i;
  logic                  stream_ready_o;
  logic                  ulpi_dir_i;
  logic                  ulpi_nxt_i;
  logic                  ulpi_stp_o;
  logic [7:0]            ulpi_data_o;

  // Expected bus words with the stp flag above the byte
  logic [8:0]            exp_q[$];
  logic [8:0]            exp_word;
  logic [31:0]           stim_lfsr;
  logic [31:0]           phy_lfsr;
  logic [31:0]           nxt_bits;
  logic                  phy_active;
  logic                  dir_prev;
  int                    pkt_len[21];
  int                    total_bytes;
  int                    cycles;
  int                    cycle_limit;
  logic [31:0]           rd;
  logic                  err;
  logic [31:0]           r;
  ulpi_pkg::ulpi_txcmd_u cmd;

  always #4 clock = ~clock;

  ulpi_tx_top i_dut (
    .clock         (clock),
    .reset         (reset),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .stream_i      (stream_i),
    .stream_ready_o(stream_ready_o),
    .ulpi_dir_i    (ulpi_dir_i),
    .ulpi_nxt_i    (ulpi_nxt_i),
    .ulpi_stp_o    (ulpi_stp_o),
    .ulpi_data_o   (ulpi_data_o)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  task automatic draw(inout logic [31:0] state, input int nbits, output logic [31:0] value);
    value = '0;
    for (int k = 0; k < nbits; k++) begin
      state = lfsr_step(state);
      value = {value[30:0], state[0]};
    end
  endtask

  // Reflected USB CRC16 from an all-ones start, sent inverted with the low byte first
  function automatic logic [15:0] ref_crc16(input logic [7:0] bytes [16], input int len);
    logic [15:0] crc;
    crc = 16'hffff;
    for (int n = 0; n < len; n++) begin
      for (int b = 0; b < 8; b++) begin
        if (crc[0] ^ bytes[n][b]) begin
          crc = (crc >> 1) ^ 16'ha001;
        end else begin
          crc = crc >> 1;
        end
      end
    end
    return ~crc;
  endfunction

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
      stop_with_failure();
    end
  endtask

  // Setup phase then access phase with pready expected high
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    @(negedge clock);
    apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(negedge clock);
    apb_req_i.penable = 1'b1;
    @(posedge clock);
    check_value("pready", 32'(apb_rsp_o.pready), 32'd1);
    rdata  = apb_rsp_o.prdata;
    slverr = apb_rsp_o.pslverr;
    @(negedge clock);
    apb_req_i = '0;
  endtask

  // Poll STATUS until a done flag shows
  task automatic wait_status(input int bit_idx);
    logic [31:0] value;
    logic        slverr;
    value = '0;
    while (value[bit_idx] == 1'b0) begin
      apb_access(1'b0, ulpi_pkg::REG_STATUS, 32'd0, value, slverr);
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge clock);
    end
  endtask

  // One packet that can wait behind the PHY owning the bus
  task automatic send_packet(input int len, input int hold_cycles);
    logic [31:0]           rnd;
    logic [3:0]            pid;
    logic [7:0]            pay [16];
    logic [15:0]           crc;
    ulpi_pkg::ulpi_txcmd_u txcmd;
    int                    sent;
    int                    hold_left;
    draw(stim_lfsr, 4, rnd);
    pid = rnd[3:0];
    for (int n = 0; n < 16; n++) begin
      pay[n] = 8'h00;
      if (n < len) begin
        draw(stim_lfsr, 8, rnd);
        pay[n] = rnd[7:0];
      end
    end
    crc = ref_crc16(pay, len);
    txcmd           = '0;
    txcmd.xmit.code = ulpi_pkg::TXCMD_TRANSMIT;
    txcmd.xmit.pid  = pid;
    exp_q.push_back({1'b0, txcmd});
    for (int n = 0; n < len; n++) begin
      exp_q.push_back({1'b0, pay[n]});
    end
    exp_q.push_back({1'b0, crc[7:0]});
    exp_q.push_back({1'b0, crc[15:8]});
    exp_q.push_back({1'b1, ulpi_pkg::TX_STOP_DATA});
    sent      = 0;
    hold_left = hold_cycles;
    while (sent < len) begin
      @(negedge clock);
      ulpi_dir_i = hold_left > 0;
      if (hold_left > 0) begin
        hold_left--;
      end
      stream_i.tvalid = 1'b1;
      stream_i.tlast  = sent == len - 1;
      stream_i.tuser  = pid;
      stream_i.tdata  = pay[sent];
      @(posedge clock);
      if (stream_ready_o) begin
        sent++;
      end
    end
    @(negedge clock);
    stream_i   = '0;
    ulpi_dir_i = 1'b0;
    wait_drained();
  endtask

  // PHY model raises nxt only once a TX CMD is on the bus
  always @(negedge clock) begin
    draw(phy_lfsr, 1, nxt_bits);
    ulpi_nxt_i = phy_active && nxt_bits[0];
  end

  // Compare accepted bytes and the stp cycle with the expected queue
  always @(posedge clock) begin
    if (!reset) begin
      if (ulpi_dir_i || dir_prev) begin
        check_value("ulpi_stp_o", 32'(ulpi_stp_o), 32'd0);
        check_value("ulpi_data_o", 32'(ulpi_data_o), 32'd0);
        check_value("stream_ready_o", 32'(stream_ready_o), 32'd0);
      end
      if (ulpi_stp_o || (ulpi_nxt_i && !ulpi_dir_i)) begin
        if (exp_q.size() == 0) begin
          $display("A byte was sent on the ULPI bus when no job was expected");
          stop_with_failure();
        end else begin
          exp_word = exp_q.pop_front();
          check_value("{ulpi_stp_o,ulpi_data_o}", 32'({ulpi_stp_o, ulpi_data_o}),
                      32'(exp_word));
        end
      end
      if (ulpi_stp_o) begin
        phy_active <= 1'b0;
      end else if (ulpi_data_o != 8'h00) begin
        phy_active <= 1'b1;
      end
    end
    dir_prev <= ulpi_dir_i;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, a job never finished", cycles);
      stop_with_failure();
    end
  end

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    apb_req_i   = '0;
    stream_i    = '0;
    ulpi_dir_i  = 1'b0;
    ulpi_nxt_i  = 1'b0;
    stim_lfsr   = 32'h4aed;
    phy_lfsr    = 32'h4aed;
    phy_active  = 1'b0;
    dir_prev    = 1'b0;
    cycles      = 0;
    // Register write and handshake bytes plus every packet
    total_bytes = 5;
    for (int k = 0; k < 21; k++) begin
      draw(stim_lfsr, 4, r);
      pkt_len[k]  = int'(r[3:0]) + 1;
      total_bytes = total_bytes + pkt_len[k] + 4;
    end
    cycle_limit = 40 * total_bytes + 2000;
    repeat (5) @(negedge clock);
    reset = 1'b0;

    // Idle outputs after reset
    @(posedge clock);
    check_value("ulpi_stp_o", 32'(ulpi_stp_o), 32'd0);
    check_value("ulpi_data_o", 32'(ulpi_data_o), 32'd0);
    check_value("stream_ready_o", 32'(stream_ready_o), 32'd0);
    apb_access(1'b0, ulpi_pkg::REG_STATUS, 32'd0, rd, err);
    check_value("STATUS", rd, 32'd0);

    // PHY register write
    apb_access(1'b1, ulpi_pkg::REG_PHY, 32'h0000_5c2a, rd, err);
    cmd           = '0;
    cmd.regw.code = ulpi_pkg::TXCMD_REGWRITE;
    cmd.regw.addr = 6'h2a;
    exp_q.push_back({1'b0, cmd});
    exp_q.push_back({1'b0, 8'h5c});
    exp_q.push_back({1'b1, ulpi_pkg::TX_STOP_DATA});
    apb_access(1'b1, ulpi_pkg::REG_CTRL, 32'h1, rd, err);
    wait_status(1);
    check_value("ULPI bytes still expected", 32'(exp_q.size()), 32'd0);
    apb_access(1'b1, ulpi_pkg::REG_STATUS, 32'h2, rd, err);
    apb_access(1'b0, ulpi_pkg::REG_STATUS, 32'd0, rd, err);
    check_value("STATUS", rd, 32'd0);

    // ACK handshake
    apb_access(1'b1, ulpi_pkg::REG_HSK, 32'h2, rd, err);
    cmd           = '0;
    cmd.xmit.code = ulpi_pkg::TXCMD_TRANSMIT;
    cmd.xmit.pid  = 4'h2;
    exp_q.push_back({1'b0, cmd});
    exp_q.push_back({1'b1, ulpi_pkg::TX_STOP_DATA});
    apb_access(1'b1, ulpi_pkg::REG_CTRL, 32'h2, rd, err);
    wait_status(2);
    check_value("ULPI bytes still expected", 32'(exp_q.size()), 32'd0);
    apb_access(1'b0, ulpi_pkg::REG_STATUS, 32'd0, rd, err);
    check_value("STATUS", rd, 32'h4);

    // Random packets and one that waits behind dir
    for (int k = 0; k < 20; k++) begin
      send_packet(pkt_len[k], 0);
    end
    send_packet(pkt_len[20], 20);

    // Register map
    apb_access(1'b0, 8'h10, 32'd0, rd, err);
    check_value("pslverr", 32'(err), 32'd1);
    apb_access(1'b1, ulpi_pkg::REG_PHY, 32'hffff_a5ff, rd, err);
    apb_access(1'b0, ulpi_pkg::REG_PHY, 32'd0, rd, err);
    check_value("REG_PHY", rd, 32'h0000_a53f);
    check_value("pslverr", 32'(err), 32'd0);
    apb_access(1'b1, ulpi_pkg::REG_HSK, 32'hffff_fff9, rd, err);
    apb_access(1'b0, ulpi_pkg::REG_HSK, 32'd0, rd, err);
    check_value("REG_HSK", rd, 32'h0000_0009);

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- compile.f
verilog/ulpi_pkg.sv
verilog/ulpi_tx_regs.sv
verilog/usb_crc16.sv
verilog/skid_loader.sv
verilog/ulpi_encoder.sv
verilog/ulpi_tx_top.sv
sim/tb_ulpi_tx.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_ulpi_tx
FILELIST  ?= compile.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "Result: PASSED"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
